//--- Makefile
# Verilator build and run of the tile memory testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_tile_mem, log to sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_mem \
		-f flist.f -Mdir obj_dir
	./obj_dir/Vtb_tile_mem | tee sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- flist.f
src/tile_cfg_pkg.sv
src/wb_pkg.sv
src/l1_sram_bank.sv
src/l1_bank_arbiter.sv
src/l1_interconnect.sv
src/tile_addr_demux.sv
src/tile_mem_top.sv
verif/tb_clk_gen.sv
verif/tb_tile_mem.sv

//--- src/l1_bank_arbiter.sv
// Round-robin arbiter for one L1 bank, processor and DMA requesters
// Grant is registered into a one-cycle ack
`timescale 1ns/100ps

module l1_bank_arbiter (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [1:0] req_i,    // Bit 0 processor, bit 1 DMA
  input  logic [1:0] busy_i,   // Requester sees its ack this cycle
  output logic [1:0] gnt_o,
  output logic [1:0] ack_o
);

  logic [1:0] act_req;   // Requests eligible for a grant
  logic       prio_q;    // Favoured requester on a conflict
  logic [1:0] ack_q;

  // A request in its ack cycle is already served
  assign act_req = req_i & ~busy_i;

  always_comb begin
    gnt_o = 2'b00;
    if (act_req == 2'b11) begin
      gnt_o[prio_q] = 1'b1;   // Conflict goes to the pointer
    end else begin
      gnt_o = act_req;        // At most one contender
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;         // Processor first
      ack_q  <= 2'b00;
    end else begin
      ack_q <= gnt_o;
      if (act_req == 2'b11) begin
        prio_q <= ~prio_q;    // Last winner loses next conflict
      end
    end
  end

  assign ack_o = ack_q;

  // One grant at most and none to a requester in its ack cycle
  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o) && ((gnt_o & ack_o) == 2'b00));

  // Every grant reaches its requester as an ack on the next edge
  a_ack_after_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_o != 2'b00) |=> ((busy_i & $past(gnt_o)) == $past(gnt_o)));

endmodule

//--- src/l1_interconnect.sv
// L1 interconnect for two requesters over four word-interleaved banks
// Per-bank round-robin arbitration and registered response steering
`timescale 1ns/100ps

module l1_interconnect
  import tile_cfg_pkg::*;
  import wb_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t req_a_i,   // Processor side
  output wb_rsp_t rsp_a_o,
  input  wb_req_t req_b_i,   // DMA side
  output wb_rsp_t rsp_b_o
);

  wb_req_t [1:0]                 req;          // Index 0 processor, 1 DMA
  wb_rsp_t [1:0]                 rsp;
  logic    [1:0]                 req_busy;     // Ack per requester
  logic    [1:0]                 req_gnt;      // Granted by any bank
  logic    [1:0][BANK_IDX_W-1:0] srv_bank_q;   // Bank that served the requester
  logic    [N_BANKS-1:0][1:0]    bank_req;
  logic    [N_BANKS-1:0][1:0]    bank_gnt;
  logic    [N_BANKS-1:0][1:0]    bank_ack;
  logic    [N_BANKS-1:0][DATA_W-1:0] bank_rdata;

  assign req     = {req_b_i, req_a_i};
  assign rsp_a_o = rsp[0];
  assign rsp_b_o = rsp[1];

  // Bank decode from the l1 view, region bits do not matter here
  always_comb begin
    bank_req = '0;
    req_gnt  = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      for (int r = 0; r < 2; r++) begin
        bank_req[b][r] = req[r].cyc && req[r].stb
                         && (req[r].adr.l1.bank_idx == BANK_IDX_W'(b));
        req_gnt[r]     = req_gnt[r] | bank_gnt[b][r];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      srv_bank_q <= '0;
    end else begin
      for (int r = 0; r < 2; r++) begin
        if (req_gnt[r]) srv_bank_q[r] <= req[r].adr.l1.bank_idx;
      end
    end
  end

  // Ack and read data come from the recorded bank, one cycle after grant
  always_comb begin
    for (int r = 0; r < 2; r++) begin
      rsp[r].ack  = bank_ack[srv_bank_q[r]][r];
      rsp[r].err  = 1'b0;
      rsp[r].dat  = bank_rdata[srv_bank_q[r]];
      req_busy[r] = rsp[r].ack;
    end
  end

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    wb_req_t win;   // Granted requester of this bank

    assign win = bank_gnt[b][1] ? req[1] : req[0];

    l1_bank_arbiter i_arb (
      .clk_i  ( clk_i       ),
      .rst_ni ( rst_ni      ),
      .req_i  ( bank_req[b] ),
      .busy_i ( req_busy    ),
      .gnt_o  ( bank_gnt[b] ),
      .ack_o  ( bank_ack[b] )
    );

    l1_sram_bank i_sram (
      .clk_i   ( clk_i               ),
      .en_i    ( |bank_gnt[b]        ),
      .we_i    ( win.we              ),
      .addr_i  ( win.adr.l1.word_idx ),
      .wdata_i ( win.dat             ),
      .sel_i   ( win.sel             ),
      .rdata_o ( bank_rdata[b]       )
    );
  end

endmodule

//--- src/l1_sram_bank.sv
// Single-port synchronous L1 bank, byte-masked write, registered read
`timescale 1ns/100ps

module l1_sram_bank
  import tile_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [WORD_IDX_W-1:0] addr_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [SEL_W-1:0]      sel_i,
  output logic [DATA_W-1:0]     rdata_o
);

  logic [DATA_W-1:0] mem [WORDS_PER_BANK];

  // Known contents at time zero in simulation
  initial begin
    for (int i = 0; i < WORDS_PER_BANK; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel_i[b]) mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];   // Masked byte lane
        end
      end
      rdata_o <= mem[addr_i];   // Old data on a write
    end
  end

endmodule

//--- src/tile_addr_demux.sv
// Processor port address decode into L1, L2 or bus error
// Unmapped accesses end with a registered one-cycle err
`timescale 1ns/100ps

module tile_addr_demux
  import tile_cfg_pkg::*;
  import wb_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t core_req_i,
  output wb_rsp_t core_rsp_o,
  output wb_req_t l1_req_o,
  input  wb_rsp_t l1_rsp_i,
  output wb_req_t l2_req_o,
  input  wb_rsp_t l2_rsp_i
);

  logic l1_hit;     // Address inside L1 window
  logic l2_hit;     // Address inside L2 window
  logic unmapped;   // Strobe to a hole in the map
  logic err_q;

  assign l1_hit   = (core_req_i.adr.raw >= L1_BASE) && (core_req_i.adr.raw <= L1_END);
  assign l2_hit   = (core_req_i.adr.raw >= L2_BASE) && (core_req_i.adr.raw <= L2_END);
  assign unmapped = core_req_i.cyc && core_req_i.stb && !l1_hit && !l2_hit;

  // Fields pass unchanged, only cyc and stb are steered
  always_comb begin
    l1_req_o     = core_req_i;
    l1_req_o.cyc = core_req_i.cyc && l1_hit;
    l1_req_o.stb = core_req_i.stb && l1_hit;
    l2_req_o     = core_req_i;
    l2_req_o.cyc = core_req_i.cyc && l2_hit;
    l2_req_o.stb = core_req_i.stb && l2_hit;
  end

  // One err per unmapped request, master drops stb after sampling it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped && !err_q;
    end
  end

  // Response follows the window of the held address
  always_comb begin
    core_rsp_o = '0;
    if (l1_hit) begin
      core_rsp_o = l1_rsp_i;
    end else if (l2_hit) begin
      core_rsp_o = l2_rsp_i;
    end else begin
      core_rsp_o.err = err_q;
    end
  end

  a_one_target : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(l1_req_o.stb && l2_req_o.stb));

  // Bus error only ever answers an unmapped strobe of the previous cycle
  a_err_after_stb : assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_o.err |-> $past(unmapped));

endmodule

//--- src/tile_cfg_pkg.sv
// Tile memory map and L1 scratchpad geometry
// Address union with a raw view and an L1 bank/row view
package tile_cfg_pkg;

  localparam int ADDR_W         = 32;   // Address width
  localparam int DATA_W         = 32;   // Data width
  localparam int SEL_W          = 4;    // One byte enable per byte
  localparam int N_BANKS        = 4;    // Word-interleaved L1 banks
  localparam int BANK_IDX_W     = 2;
  localparam int WORDS_PER_BANK = 256;
  localparam int WORD_IDX_W     = 8;

  // 4 KiB of L1 scratchpad
  localparam logic [ADDR_W-1:0] L1_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] L1_END  = 32'h1000_0FFF;

  // External L2 window
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] L2_END  = 32'h8FFF_FFFF;

  // L1 layout, low bits pick the bank so consecutive words hit different banks
  typedef struct packed {
    logic [ADDR_W-WORD_IDX_W-BANK_IDX_W-$clog2(SEL_W)-1:0] region;   // Ignored by L1
    logic [WORD_IDX_W-1:0]                                 word_idx; // Row inside bank
    logic [BANK_IDX_W-1:0]                                 bank_idx; // Bank select
    logic [$clog2(SEL_W)-1:0]                              byte_off; // Covered by sel
  } l1_addr_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;   // Decoded against the memory map
    l1_addr_t          l1;    // Decoded by the interconnect
  } tile_addr_u;

endpackage

//--- src/tile_mem_top.sv
// Tile memory subsystem top level
// Processor demux, shared L1 interconnect and external L2 port
`timescale 1ns/100ps

module tile_mem_top
  import wb_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t core_req_i,   // Processor data port
  output wb_rsp_t core_rsp_o,
  input  wb_req_t dma_req_i,    // DMA port, L1 only
  output wb_rsp_t dma_rsp_o,
  output wb_req_t l2_req_o,     // Toward external L2
  input  wb_rsp_t l2_rsp_i
);

  wb_req_t core_l1_req;   // Processor share of L1
  wb_rsp_t core_l1_rsp;

  tile_addr_demux i_demux (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .core_req_i ( core_req_i  ),
    .core_rsp_o ( core_rsp_o  ),
    .l1_req_o   ( core_l1_req ),
    .l1_rsp_i   ( core_l1_rsp ),
    .l2_req_o   ( l2_req_o    ),
    .l2_rsp_i   ( l2_rsp_i    )
  );

  l1_interconnect i_l1_ic (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .req_a_i ( core_l1_req ),
    .rsp_a_o ( core_l1_rsp ),
    .req_b_i ( dma_req_i   ),
    .rsp_b_o ( dma_rsp_o   )
  );

endmodule

//--- src/wb_pkg.sv
// Wishbone classic request and response bundles
package wb_pkg;
  import tile_cfg_pkg::*;

  // Master to slave, 71 bits
  typedef struct packed {
    logic              cyc;   // Bus cycle in progress
    logic              stb;   // Valid transfer
    logic              we;    // Write when high
    tile_addr_u        adr;
    logic [DATA_W-1:0] dat;   // Write data
    logic [SEL_W-1:0]  sel;   // Byte enables
  } wb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    logic              ack;   // Normal end of transfer, one cycle
    logic              err;   // Bus error, one cycle
    logic [DATA_W-1:0] dat;   // Read data, valid with ack
  } wb_rsp_t;

endpackage

//--- verif/tb_clk_gen.sv
// Testbench clock and reset source
// 4 ns clock, active low reset held for two cycles
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;   // 4 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;              // Released on a rising edge
  end

endmodule

//--- verif/tb_tile_mem.sv
// Tile memory testbench with a stimulus table applied in a loop
// Behavioral L2 slave with LFSR latency, L1 reference array, checks and report
`timescale 1ns/100ps

module tb_tile_mem
  import tile_cfg_pkg::*;
  import wb_pkg::*;
();

  localparam int P_CORE   = 0;   // Port select of a table entry
  localparam int P_DMA    = 1;
  localparam int P_BOTH   = 2;
  localparam int TIMEOUT  = 20;  // Cycles per wait
  localparam int L1_WORDS = N_BANKS * WORDS_PER_BANK;

  typedef struct {
    int          port;
    logic        we;
    logic [31:0] adr;      // Processor address, or DMA address on a DMA entry
    logic [31:0] adr_b;    // DMA address of a paired entry
    logic [31:0] dat;      // DMA writes the inverse on a paired entry
    logic [3:0]  sel;
    logic        exp_err;
    logic [31:0] exp_dat;  // Only used on L2 reads
  } stim_t;

  logic        clk_i, rst_ni;
  wb_req_t     core_req_i, dma_req_i, l2_req_o, l2_seen;
  wb_rsp_t     core_rsp_o, dma_rsp_o, l2_rsp_i;
  stim_t       table_q [$];
  logic [31:0] ref_l1 [L1_WORDS];      // Expected L1 contents
  logic [31:0] l2_mem [logic [31:0]];  // Sparse L2 storage
  logic [15:0] lfsr_q = 16'd23329;
  int          ack_cnt [2];            // Acks seen per port
  int          l2_strobes = 0;
  int          checks = 0;
  int          errors = 0;
  logic        hung = 1'b0;

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  tile_mem_top uut (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .core_req_i ( core_req_i ),
    .core_rsp_o ( core_rsp_o ),
    .dma_req_i  ( dma_req_i  ),
    .dma_rsp_o  ( dma_rsp_o  ),
    .l2_req_o   ( l2_req_o   ),
    .l2_rsp_i   ( l2_rsp_i   )
  );

  // Taps 16 14 13 11
  function automatic logic next_rand_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic wb_req_t make_req(input logic we, input logic [31:0] adr,
                                       input logic [31:0] dat, input logic [3:0] sel);
    wb_req_t r;
    r         = '0;
    r.cyc     = 1'b1;
    r.stb     = 1'b1;
    r.we      = we;
    r.adr.raw = adr;
    r.dat     = dat;
    r.sel     = sel;
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic add_entry(input int port, input logic we, input logic [31:0] adr,
                           input logic [31:0] adr_b, input logic [31:0] dat, input logic [3:0] sel,
                           input logic exp_err, input logic [31:0] exp_dat);
    table_q.push_back('{port, we, adr, adr_b, dat, sel, exp_err, exp_dat});
  endtask

  task automatic build_table();
    add_entry(P_CORE, 1, 32'h1000_0000, 0, 32'h1122_3344, 4'hF, 0, 0);  // Full word to bank 0
    add_entry(P_CORE, 1, 32'h1000_0000, 0, 32'hAABB_CCDD, 4'h5, 0, 0);  // Bytes 0 and 2
    add_entry(P_CORE, 0, 32'h1000_0000, 0, 0, 4'hF, 0, 0);
    add_entry(P_CORE, 1, 32'h1000_0104, 0, 32'hDEAD_BEEF, 4'hC, 0, 0);  // Upper half in bank 1
    add_entry(P_DMA,  1, 32'h0000_0104, 0, 32'h0000_00A5, 4'h1, 0, 0);  // Region bits ignored
    add_entry(P_CORE, 0, 32'h1000_0104, 0, 0, 4'hF, 0, 0);
    add_entry(P_DMA,  1, 32'h0000_0028, 0, 32'hCAFE_F00D, 4'hF, 0, 0);  // Bank 2
    add_entry(P_CORE, 0, 32'h1000_0028, 0, 0, 4'hF, 0, 0);
    add_entry(P_CORE, 1, 32'h1000_003C, 0, 32'h0BAD_CAFE, 4'hF, 0, 0);  // Bank 3
    add_entry(P_DMA,  0, 32'h0000_003C, 0, 0, 4'hF, 0, 0);
    add_entry(P_BOTH, 1, 32'h1000_0040, 32'h0000_0080, 32'h1357_9BDF, 4'hF, 0, 0);  // Same bank
    add_entry(P_BOTH, 0, 32'h1000_0080, 32'h0000_0040, 0, 4'hF, 0, 0);
    add_entry(P_BOTH, 1, 32'h1000_0044, 32'h0000_0048, 32'h2468_ACE0, 4'hF, 0, 0);  // Banks 1 and 2
    add_entry(P_BOTH, 0, 32'h1000_0048, 32'h0000_0044, 0, 4'hF, 0, 0);
    add_entry(P_CORE, 1, 32'h8000_1000, 0, 32'h600D_D00D, 4'hF, 0, 0);  // L2 window
    add_entry(P_CORE, 1, 32'h8000_1000, 0, 32'h0000_1234, 4'h3, 0, 0);
    add_entry(P_CORE, 0, 32'h8000_1000, 0, 0, 4'hF, 0, 32'h600D_1234);
    add_entry(P_CORE, 0, 32'h8000_2000, 0, 0, 4'hF, 0, 32'h7FFF_DFFF);  // Unwritten word reads fill
    add_entry(P_CORE, 1, 32'h4000_0000, 0, 32'hFFFF_FFFF, 4'hF, 1, 0);  // Unmapped
    add_entry(P_CORE, 0, 32'h1000_1000, 0, 0, 4'hF, 1, 0);              // Just past L1
    add_entry(P_CORE, 0, 32'h1000_0000, 0, 0, 4'hF, 0, 0);              // Still unchanged
  endtask

  task automatic run_entry(input int idx, input stim_t e);
    logic        act [2];
    logic        pend [2];
    logic        got_ack [2];
    logic        got_err [2];
    logic [31:0] adr [2];
    logic [31:0] wdat [2];
    logic [31:0] got_dat [2];
    wb_rsp_t     rsp [2];
    int          lat [2];
    int          acks0 [2];
    int          l2_before, n;
    logic        l2_acc, err_p, no_conflict;
    logic [31:0] want;
    string       nm;
    act[0]    = (e.port != P_DMA);
    act[1]    = (e.port != P_CORE);
    adr[0]    = e.adr;
    adr[1]    = (e.port == P_BOTH) ? e.adr_b : e.adr;
    wdat[0]   = e.dat;
    wdat[1]   = (e.port == P_BOTH) ? ~e.dat : e.dat;
    l2_acc    = act[0] && (e.adr >= L2_BASE) && (e.adr <= L2_END);
    l2_before = l2_strobes;
    no_conflict = (e.port != P_BOTH) || (adr[0][3:2] != adr[1][3:2]);   // Word-interleaved banks
    for (int p = 0; p < 2; p++) begin
      pend[p]  = act[p];
      acks0[p] = ack_cnt[p];
      lat[p]   = 0;
    end
    @(posedge clk_i);
    if (act[0]) core_req_i <= make_req(e.we, adr[0], wdat[0], e.sel);
    if (act[1]) dma_req_i <= make_req(e.we, adr[1], wdat[1], e.sel);
    n = 0;
    while ((pend[0] || pend[1]) && n < TIMEOUT) begin
      @(negedge clk_i);                    // Responses settled mid cycle
      n++;
      rsp[0] = core_rsp_o;
      rsp[1] = dma_rsp_o;
      for (int p = 0; p < 2; p++) begin
        if (pend[p] && (rsp[p].ack || rsp[p].err)) begin
          pend[p]    = 1'b0;
          got_ack[p] = rsp[p].ack;
          got_err[p] = rsp[p].err;
          got_dat[p] = rsp[p].dat;
          lat[p]     = n - 1;              // Cycles after the first stb cycle
        end
      end
      @(posedge clk_i);
      if (!pend[0]) core_req_i <= '0;
      if (!pend[1]) dma_req_i <= '0;
    end
    if (pend[0] || pend[1]) begin
      $display("Timeout: table entry %0d got no ack or err within %0d cycles", idx, TIMEOUT);
      errors++;
      hung = 1'b1;
      return;
    end
    @(negedge clk_i);                      // Idle cycle catches a duplicate ack
    @(posedge clk_i);
    for (int p = 0; p < 2; p++) begin
      if (act[p]) begin
        nm    = (p == 0) ? "core_rsp_o" : "dma_rsp_o";
        err_p = (p == 0) && e.exp_err;
        check_val({nm, ".err"}, 32'(got_err[p]), 32'(err_p));
        check_val({nm, ".ack"}, 32'(got_ack[p]), 32'(!err_p));
        check_val({nm, " ack count"}, ack_cnt[p] - acks0[p], err_p ? 0 : 1);
        if (no_conflict && !l2_acc) begin
          check_val({nm, " latency"}, lat[p], 1);
        end else if (lat[p] > 3) begin
          $display("Entry %0d on %s took %0d cycles, more than 3", idx, nm, lat[p]);
          errors++;
        end
        if (!e.we && !err_p) begin
          want = (p == 0 && l2_acc) ? e.exp_dat : ref_l1[adr[p][11:2]];
          check_val({nm, ".dat"}, got_dat[p], want);
        end
        if (e.we && !err_p && !(p == 0 && l2_acc)) begin
          ref_l1[adr[p][11:2]] = merge_bytes(ref_l1[adr[p][11:2]], wdat[p], e.sel);
        end
      end
    end
    check_val("l2_req_o strobe count", l2_strobes - l2_before, l2_acc ? 1 : 0);
    if (l2_acc) begin
      check_val("l2_req_o.adr", l2_seen.adr.raw, e.adr);
      check_val("l2_req_o.sel", 32'(l2_seen.sel), 32'(e.sel));
      check_val("l2_req_o.we", 32'(l2_seen.we), 32'(e.we));
      if (e.we) check_val("l2_req_o.dat", l2_seen.dat, e.dat);
    end
  endtask

  always @(negedge clk_i) begin
    if (core_rsp_o.ack) ack_cnt[0]++;
    if (dma_rsp_o.ack) ack_cnt[1]++;
  end

  // L2 slave answering 1 to 3 cycles after the first strobe cycle
  initial begin
    logic [1:0]  r;
    logic [31:0] word;
    l2_rsp_i = '0;
    forever begin
      @(posedge clk_i);
      if (l2_req_o.cyc && l2_req_o.stb) begin
        l2_strobes++;
        l2_seen = l2_req_o;
        r[1]    = next_rand_bit();
        r[0]    = next_rand_bit();
        repeat (r % 3) @(posedge clk_i);
        word = l2_mem.exists(l2_seen.adr.raw) ? l2_mem[l2_seen.adr.raw] : ~l2_seen.adr.raw;
        if (l2_seen.we) l2_mem[l2_seen.adr.raw] = merge_bytes(word, l2_seen.dat, l2_seen.sel);
        l2_rsp_i.ack <= 1'b1;
        l2_rsp_i.dat <= word;                // Old word even on a write
        @(posedge clk_i);
        l2_rsp_i.ack <= 1'b0;
      end
    end
  end

  initial begin
    int n;
    core_req_i = '0;
    dma_req_i  = '0;
    for (int i = 0; i < L1_WORDS; i++) begin
      ref_l1[i] = '0;                      // Banks start zeroed
    end
    build_table();
    n = 0;
    while (rst_ni !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Reset was not released within %0d cycles", TIMEOUT);
      errors++;
    end else begin
      @(negedge clk_i);
      check_val("core_rsp_o.ack", 32'(core_rsp_o.ack), 0);
      check_val("core_rsp_o.err", 32'(core_rsp_o.err), 0);
      check_val("dma_rsp_o.ack", 32'(dma_rsp_o.ack), 0);
      check_val("dma_rsp_o.err", 32'(dma_rsp_o.err), 0);
      check_val("l2_req_o.cyc", 32'(l2_req_o.cyc), 0);
      foreach (table_q[i]) begin
        if (!hung) run_entry(i, table_q[i]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
